// ==== common/sdi_params.svh ====
`ifndef SDI_PARAMS_SVH
`define SDI_PARAMS_SVH

// register map.
`define SDI_CONTROL_ADDR 12'h000
`define SDI_BAUD_ADDR 12'h004

// capture modes.
`define SDI_MODE_CONSTELLATION 2'd0
`define SDI_MODE_EYE 2'd1

// samples held per channel.
`define SDI_FIFO_DEPTH 16

// bit time is divisor plus one clocks.
`define SDI_BAUD_RESET 16'd3

`endif

// ==== common/sdi_pkg.sv ====
package sdi_pkg;

    typedef logic [11:0] regAddrT;
    typedef logic [31:0] busWordT;
    typedef logic [17:0] rawSampleT; // as delivered by the demodulator.
    typedef logic [15:0] sampleT;
    typedef logic [7:0]  byteT;
    typedef logic [15:0] frameCountT;
    typedef logic [15:0] baudDivT;
    typedef logic [1:0]  modeT;

    typedef enum logic {
        eyeIdle,
        eyeWait
    } eyeStateT;

    // each byte slot has a load state and a wait state.
    typedef enum logic [3:0] {
        serIdle,
        serCntMsb, serCntMsbWait,
        serCntLsb, serCntLsbWait,
        serIMsb, serIMsbWait,
        serILsb, serILsbWait,
        serQMsb, serQMsbWait,
        serQLsb, serQLsbWait
    } serStateT;

    typedef enum logic [1:0] {
        txIdle,
        txStart,
        txData,
        txStop
    } txStateT;

endpackage

// ==== capture/sampleFifo.sv ====
module sampleFifo #(
    parameter int DEPTH = 16
) (
    input  logic            clk,
    input  logic            fifoFull,
    input  logic            clear,
    input  logic            writeEn,
    input  sdi_pkg::sampleT din,
    input  logic            readEn,
    output sdi_pkg::sampleT dout,
    output logic            full,
    output logic            empty
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    sdi_pkg::sampleT mem [DEPTH];
    logic [AW-1:0]   wrPtr;
    logic [AW-1:0]   rdPtr;
    logic [CW-1:0]   count;
    logic            doWrite;
    logic            doRead;

    function automatic logic [AW-1:0] nextPtr(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign doWrite = writeEn && !full;
    assign doRead  = readEn && !empty;
    assign full    = (count == CW'(DEPTH));
    assign empty   = (count == '0);
    assign dout    = mem[rdPtr]; // show-ahead.

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[wrPtr] <= din;
        end
    end

    always_ff @(posedge clk or posedge fifoFull) begin
        if (fifoFull) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else if (clear) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite) wrPtr <= nextPtr(wrPtr);
            if (doRead) rdPtr <= nextPtr(rdPtr);
            case ({doWrite, doRead})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== capture/symbolCapture.sv ====
`include "sdi_params.svh"

module symbolCapture (
    input  logic               clk,
    input  logic               fifoFull,
    input  logic               captureEnable,
    input  sdi_pkg::modeT      mode,
    input  logic               iSymEn,
    input  sdi_pkg::rawSampleT iSymData,
    input  sdi_pkg::rawSampleT qSymData,
    input  logic               eyeSync,
    input  sdi_pkg::rawSampleT iEye,
    input  sdi_pkg::rawSampleT qEye,
    input  logic               readEn,
    input  logic               clearFifo,
    output sdi_pkg::sampleT    iSym,
    output sdi_pkg::sampleT    qSym,
    output logic               fifoEmpty,
    output logic               captureFull,
    output logic               capturing
);

    logic              enableMeta;
    sdi_pkg::eyeStateT eyeState;
    logic              constMode;
    logic              eyeWrite;
    logic              writeEn;
    sdi_pkg::sampleT   iIn;
    sdi_pkg::sampleT   qIn;

    always_ff @(posedge clk or posedge fifoFull) begin
        if (fifoFull) begin
            enableMeta <= 1'b0;
            capturing  <= 1'b0;
        end else begin
            enableMeta <= captureEnable;
            capturing  <= enableMeta;
        end
    end

    // waits for the first qualified eye strobe, then takes every strobe.
    always_ff @(posedge clk or posedge fifoFull) begin
        if (fifoFull) begin
            eyeState <= sdi_pkg::eyeIdle;
        end else begin
            case (eyeState)
                sdi_pkg::eyeIdle: begin
                    if (eyeSync && capturing && iSymEn) begin
                        eyeState <= sdi_pkg::eyeWait;
                    end
                end
                sdi_pkg::eyeWait: begin
                    if (!capturing) begin
                        eyeState <= sdi_pkg::eyeIdle;
                    end
                end
                default: eyeState <= sdi_pkg::eyeIdle;
            endcase
        end
    end

    assign constMode = (mode == `SDI_MODE_CONSTELLATION);
    assign eyeWrite  = eyeSync && (eyeState == sdi_pkg::eyeWait || iSymEn);
    assign writeEn   = capturing && !captureFull && (constMode ? iSymEn : eyeWrite);

    // keep the top 16 of 18 bits.
    assign iIn = constMode ? iSymData[17:2] : iEye[17:2];
    assign qIn = constMode ? qSymData[17:2] : qEye[17:2];

    sampleFifo #(.DEPTH(`SDI_FIFO_DEPTH)) iFifo (
        .clk(clk), .fifoFull(fifoFull), .clear(clearFifo),
        .writeEn(writeEn), .din(iIn), .readEn(readEn), .dout(iSym),
        .full(captureFull), .empty(fifoEmpty)
    );

    // q side tracks i exactly.
    sampleFifo #(.DEPTH(`SDI_FIFO_DEPTH)) qFifo (
        .clk(clk), .fifoFull(fifoFull), .clear(clearFifo),
        .writeEn(writeEn), .din(qIn), .readEn(readEn), .dout(qSym),
        .full(), .empty()
    );

endmodule

// ==== uart/frameSerializer.sv ====
module frameSerializer (
    input  logic                clk,
    input  logic                fifoFull,
    input  logic                capturing,
    input  logic                fifoEmpty,
    input  sdi_pkg::sampleT     iSym,
    input  sdi_pkg::sampleT     qSym,
    output logic                readEn,
    output logic                clearFifo,
    output sdi_pkg::byteT       txByte,
    output logic                dataAvailable,
    input  logic                dataNeeded
);

    sdi_pkg::serStateT   state;
    sdi_pkg::frameCountT frameCount;

    // load states wait for the uart to take the byte, wait states for it to go idle.
    always_ff @(posedge clk or posedge fifoFull) begin
        if (fifoFull) begin
            state         <= sdi_pkg::serIdle;
            readEn        <= 1'b0;
            clearFifo     <= 1'b0;
            txByte        <= '0;
            dataAvailable <= 1'b0;
            frameCount    <= '0;
        end else begin
            readEn    <= 1'b0;
            clearFifo <= 1'b0;
            case (state)
                sdi_pkg::serIdle: begin
                    if (!capturing && !fifoEmpty && dataNeeded) begin
                        state         <= sdi_pkg::serCntMsb;
                        dataAvailable <= 1'b1;
                        txByte        <= frameCount[15:8];
                    end
                end
                sdi_pkg::serCntMsb: if (!dataNeeded) state <= sdi_pkg::serCntMsbWait;
                sdi_pkg::serCntMsbWait: begin
                    if (dataNeeded) begin
                        state      <= sdi_pkg::serCntLsb;
                        txByte     <= frameCount[7:0];
                        frameCount <= frameCount + 1'b1;
                    end
                end
                sdi_pkg::serCntLsb: if (!dataNeeded) state <= sdi_pkg::serCntLsbWait;
                sdi_pkg::serCntLsbWait: begin
                    if (dataNeeded) begin
                        state  <= sdi_pkg::serIMsb;
                        txByte <= iSym[15:8];
                    end
                end
                sdi_pkg::serIMsb: if (!dataNeeded) state <= sdi_pkg::serIMsbWait;
                sdi_pkg::serIMsbWait: begin
                    if (dataNeeded) begin
                        state  <= sdi_pkg::serILsb;
                        txByte <= iSym[7:0];
                    end
                end
                sdi_pkg::serILsb: if (!dataNeeded) state <= sdi_pkg::serILsbWait;
                sdi_pkg::serILsbWait: begin
                    if (dataNeeded) begin
                        state  <= sdi_pkg::serQMsb;
                        txByte <= qSym[15:8];
                    end
                end
                sdi_pkg::serQMsb: if (!dataNeeded) state <= sdi_pkg::serQMsbWait;
                sdi_pkg::serQMsbWait: begin
                    if (dataNeeded) begin
                        state  <= sdi_pkg::serQLsb;
                        txByte <= qSym[7:0];
                        readEn <= 1'b1; // pop the pair.
                    end
                end
                sdi_pkg::serQLsb: if (!dataNeeded) state <= sdi_pkg::serQLsbWait;
                sdi_pkg::serQLsbWait: begin
                    if (fifoEmpty) begin
                        state         <= sdi_pkg::serIdle;
                        dataAvailable <= 1'b0;
                        clearFifo     <= 1'b1;
                        frameCount    <= '0;
                    end else if (dataNeeded) begin
                        state  <= sdi_pkg::serCntMsb;
                        txByte <= frameCount[15:8];
                    end
                end
                default: begin
                    state         <= sdi_pkg::serIdle;
                    dataAvailable <= 1'b0;
                    frameCount    <= '0;
                end
            endcase
        end
    end

endmodule

// ==== uart/uartTx.sv ====
module uartTx (
    input  logic             clk,
    input  logic             fifoFull,
    input  sdi_pkg::baudDivT baudDiv,
    input  sdi_pkg::byteT    txByte,
    input  logic             dataAvailable,
    output logic             dataNeeded,
    output logic             sdiOut
);

    sdi_pkg::txStateT state;
    sdi_pkg::baudDivT baudCnt;
    sdi_pkg::byteT    shiftReg;
    logic [2:0]       bitIdx;
    logic             armed;
    logic             accept;
    logic             baudTick;

    assign dataNeeded = (state == sdi_pkg::txIdle);
    // one idle cycle first, so the serializer can swap in its next byte.
    assign accept     = dataNeeded && armed && dataAvailable;
    assign baudTick   = (baudCnt == '0);

    always_ff @(posedge clk or posedge fifoFull) begin
        if (fifoFull) begin
            state    <= sdi_pkg::txIdle;
            baudCnt  <= '0;
            shiftReg <= '0;
            bitIdx   <= '0;
            armed    <= 1'b0;
            sdiOut   <= 1'b1;
        end else begin
            armed <= dataNeeded;
            if (accept || baudTick) begin
                baudCnt <= baudDiv; // restart so the start bit is full length.
            end else begin
                baudCnt <= baudCnt - 1'b1;
            end
            case (state)
                sdi_pkg::txIdle: begin
                    if (accept) begin
                        shiftReg <= txByte;
                        sdiOut   <= 1'b0;
                        state    <= sdi_pkg::txStart;
                    end
                end
                sdi_pkg::txStart: begin
                    if (baudTick) begin
                        sdiOut   <= shiftReg[0];
                        shiftReg <= shiftReg >> 1;
                        bitIdx   <= '0;
                        state    <= sdi_pkg::txData;
                    end
                end
                sdi_pkg::txData: begin
                    if (baudTick) begin
                        if (bitIdx == 3'd7) begin
                            sdiOut <= 1'b1; // stop bit.
                            state  <= sdi_pkg::txStop;
                        end else begin
                            sdiOut   <= shiftReg[0];
                            shiftReg <= shiftReg >> 1;
                            bitIdx   <= bitIdx + 1'b1;
                        end
                    end
                end
                sdi_pkg::txStop: if (baudTick) state <= sdi_pkg::txIdle;
                default: begin
                    state  <= sdi_pkg::txIdle;
                    sdiOut <= 1'b1;
                end
            endcase
        end
    end

endmodule

// ==== rtl/sdiRegs.sv ====
`include "sdi_params.svh"

module sdiRegs (
    input  logic             clk,
    input  logic             fifoFull,
    input  sdi_pkg::regAddrT addr,
    input  sdi_pkg::busWordT dataIn,
    input  logic             wr,
    output sdi_pkg::busWordT dataOut,
    input  logic             captureFull,
    input  logic             fifoEmpty,
    output logic             captureEnable,
    output sdi_pkg::modeT    mode,
    output sdi_pkg::baudDivT baudDiv
);

    logic controlSel;
    logic baudSel;

    assign controlSel = (addr == `SDI_CONTROL_ADDR);
    assign baudSel    = (addr == `SDI_BAUD_ADDR);

    always_ff @(posedge clk or posedge fifoFull) begin
        if (fifoFull) begin
            captureEnable <= 1'b0;
            mode          <= `SDI_MODE_CONSTELLATION;
            baudDiv       <= `SDI_BAUD_RESET;
        end else begin
            if (wr && controlSel) begin
                captureEnable <= dataIn[7];
                mode          <= dataIn[1:0];
            end
            if (captureFull) begin
                captureEnable <= 1'b0; // full stops capture, even over a write.
            end
            if (wr && baudSel) begin
                baudDiv <= dataIn[15:0];
            end
        end
    end

    always_comb begin
        dataOut = '0;
        if (controlSel) begin
            dataOut = {fifoEmpty, 23'b0, captureEnable, 5'b0, mode};
        end else if (baudSel) begin
            dataOut = {16'b0, baudDiv};
        end
    end

endmodule

// ==== rtl/sdiTop.sv ====
module sdiTop (
    input  logic               clk,
    input  logic               fifoFull,
    input  sdi_pkg::regAddrT   addr,
    input  sdi_pkg::busWordT   dataIn,
    input  logic               wr,
    output sdi_pkg::busWordT   dataOut,
    input  logic               iSymEn,
    input  sdi_pkg::rawSampleT iSymData,
    input  sdi_pkg::rawSampleT qSymData,
    input  logic               eyeSync,
    input  sdi_pkg::rawSampleT iEye,
    input  sdi_pkg::rawSampleT qEye,
    output logic               sdiOut
);

    logic             captureEnable;
    sdi_pkg::modeT    mode;
    sdi_pkg::baudDivT baudDiv;
    logic             captureFull;
    logic             fifoEmpty;
    logic             capturing;
    sdi_pkg::sampleT  iSym;
    sdi_pkg::sampleT  qSym;
    logic             readEn;
    logic             clearFifo;
    sdi_pkg::byteT    txByte;
    logic             dataAvailable;
    logic             dataNeeded;

    sdiRegs regs (
        .clk(clk), .fifoFull(fifoFull),
        .addr(addr), .dataIn(dataIn), .wr(wr), .dataOut(dataOut),
        .captureFull(captureFull), .fifoEmpty(fifoEmpty),
        .captureEnable(captureEnable), .mode(mode), .baudDiv(baudDiv)
    );

    symbolCapture capture (
        .clk(clk), .fifoFull(fifoFull),
        .captureEnable(captureEnable), .mode(mode),
        .iSymEn(iSymEn), .iSymData(iSymData), .qSymData(qSymData),
        .eyeSync(eyeSync), .iEye(iEye), .qEye(qEye),
        .readEn(readEn), .clearFifo(clearFifo),
        .iSym(iSym), .qSym(qSym), .fifoEmpty(fifoEmpty),
        .captureFull(captureFull), .capturing(capturing)
    );

    frameSerializer serializer (
        .clk(clk), .fifoFull(fifoFull),
        .capturing(capturing), .fifoEmpty(fifoEmpty), .iSym(iSym), .qSym(qSym),
        .readEn(readEn), .clearFifo(clearFifo),
        .txByte(txByte), .dataAvailable(dataAvailable), .dataNeeded(dataNeeded)
    );

    uartTx uart (
        .clk(clk), .fifoFull(fifoFull), .baudDiv(baudDiv),
        .txByte(txByte), .dataAvailable(dataAvailable), .dataNeeded(dataNeeded),
        .sdiOut(sdiOut)
    );

endmodule

// ==== tests/sdi_sva.sv ====
module sdiSva (
    input logic clk,
    input logic fifoFull,
    input logic captureFull,
    input logic readEn,
    input logic clearFifo,
    input logic fifoEmpty,
    input logic dataAvailable,
    input logic capturing,
    input logic sdiOut
);

    // a write into a full FIFO would move it off full.
    noWriteWhenFull: assert property (@(posedge clk) disable iff (fifoFull)
        captureFull && !readEn && !clearFifo |=> captureFull)
        else $error("FIFO written while full");

    noReadWhenEmpty: assert property (@(posedge clk) disable iff (fifoFull)
        !(readEn && fifoEmpty))
        else $error("FIFO read while empty");

    // draining never begins during capture.
    noDrainWhileCapturing: assert property (@(posedge clk) disable iff (fifoFull)
        $rose(dataAvailable) |-> !capturing)
        else $error("dataAvailable rose while capturing");

    lineIdleAfterReset: assert property (@(posedge clk) $fell(fifoFull) |-> sdiOut)
        else $error("sdiOut low after reset");

endmodule

bind sdiTop sdiSva sva (
    .clk(clk), .fifoFull(fifoFull),
    .captureFull(captureFull), .readEn(readEn), .clearFifo(clearFifo),
    .fifoEmpty(fifoEmpty),
    .dataAvailable(dataAvailable), .capturing(capturing), .sdiOut(sdiOut)
);

// ==== tests/sdiTb.sv ====
`include "sdi_params.svh"

module sdiTb;

    localparam int TIMEOUT_CYCLES = 25000; // four 16-frame drains plus margin.
    localparam int BAUD_DIV = 3;

    logic               clk;
    logic               fifoFull;
    sdi_pkg::regAddrT   addr;
    sdi_pkg::busWordT   dataIn;
    logic               wr;
    sdi_pkg::busWordT   dataOut;
    logic               iSymEn;
    sdi_pkg::rawSampleT iSymData;
    sdi_pkg::rawSampleT qSymData;
    logic               eyeSync;
    sdi_pkg::rawSampleT iEye;
    sdi_pkg::rawSampleT qEye;
    logic               sdiOut;

    int              errors = 0;
    int              checks = 0;
    int              cycles = 0;
    sdi_pkg::byteT   rxBytes[$];
    sdi_pkg::sampleT expI[$];
    sdi_pkg::sampleT expQ[$];

    sdiTop DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic busWrite(input sdi_pkg::regAddrT a, input sdi_pkg::busWordT d);
        @(posedge clk);
        #1;
        addr   = a;
        dataIn = d;
        wr     = 1'b1;
        @(posedge clk);
        #1;
        wr = 1'b0;
    endtask

    task automatic busRead(input sdi_pkg::regAddrT a, output sdi_pkg::busWordT d);
        @(posedge clk);
        #1;
        addr = a;
        @(negedge clk);
        d = dataOut;
    endtask

    // 8N1 decode sampled near mid-bit.
    task automatic uartRecvByte(output sdi_pkg::byteT b);
        int k;
        @(negedge clk);
        while (sdiOut !== 1'b0) @(negedge clk);
        repeat ((BAUD_DIV + 1) / 2 - 1) @(negedge clk);
        for (k = 0; k < 8; k++) begin
            repeat (BAUD_DIV + 1) @(negedge clk);
            b[k] = sdiOut;
        end
        repeat (BAUD_DIV + 1) @(negedge clk);
        if (sdiOut !== 1'b1) begin
            errors++;
            $display("framing error: stop bit not high at time %0t", $time);
        end
    endtask

    initial begin : rxMonitor
        sdi_pkg::byteT b;
        forever begin
            uartRecvByte(b);
            rxBytes.push_back(b);
        end
    end

    task automatic captureSymbols(input int count);
        int k;
        logic [31:0] rnd;
        busWrite(`SDI_CONTROL_ADDR, 32'h80 | `SDI_MODE_CONSTELLATION);
        @(posedge clk); // capturing is high two edges after the write.
        for (k = 0; k < count; k++) begin
            @(posedge clk);
            #1;
            rnd      = $urandom();
            iSymData = rnd[17:0];
            rnd      = $urandom();
            qSymData = rnd[17:0];
            iSymEn   = 1'b1;
            if (k < `SDI_FIFO_DEPTH) begin
                expI.push_back(iSymData[17:2]);
                expQ.push_back(qSymData[17:2]);
            end
        end
        @(posedge clk);
        #1;
        iSymEn = 1'b0;
    endtask

    task automatic drainAndCheck(input int frames);
        int f;
        int base;
        while (rxBytes.size() < frames * 6) @(posedge clk);
        repeat (2 * 10 * (BAUD_DIV + 1)) @(posedge clk); // time for a stray byte.
        check(rxBytes.size(), frames * 6, "received byte count");
        for (f = 0; f < frames; f++) begin
            base = f * 6;
            check({rxBytes[base], rxBytes[base + 1]}, f, "frame count");
            check({rxBytes[base + 2], rxBytes[base + 3]}, expI[f], "I sample");
            check({rxBytes[base + 4], rxBytes[base + 5]}, expQ[f], "Q sample");
        end
        rxBytes.delete();
        expI.delete();
        expQ.delete();
    endtask

    task automatic resetValues();
        sdi_pkg::busWordT d;
        busRead(`SDI_CONTROL_ADDR, d);
        check(d, 32'h8000_0000, "control after reset");
        busRead(`SDI_BAUD_ADDR, d);
        check(d, 32'd3, "baud after reset");
        busWrite(`SDI_BAUD_ADDR, 32'hffff_0000 | BAUD_DIV); // upper half is not stored.
        busRead(`SDI_BAUD_ADDR, d);
        check(d, BAUD_DIV, "baud after write");
    endtask

    task automatic constellationCapture();
        sdi_pkg::busWordT d;
        captureSymbols(5);
        busWrite(`SDI_CONTROL_ADDR, 32'h0);
        busRead(`SDI_CONTROL_ADDR, d);
        check(d[7], 1'b0, "enable after host stop");
        drainAndCheck(5);
    endtask

    task automatic fullStop();
        sdi_pkg::busWordT d;
        captureSymbols(20);
        busRead(`SDI_CONTROL_ADDR, d); // still draining here.
        check(d[7], 1'b0, "enable after full");
        drainAndCheck(`SDI_FIFO_DEPTH);
    endtask

    task automatic eyeModeCapture();
        int k;
        logic [31:0] rnd;
        busWrite(`SDI_CONTROL_ADDR, 32'h80 | `SDI_MODE_EYE);
        @(posedge clk);
        for (k = 0; k < 18; k++) begin
            @(posedge clk);
            #1;
            rnd      = $urandom();
            iEye     = rnd[17:0];
            rnd      = $urandom();
            qEye     = rnd[17:0];
            rnd      = $urandom();
            iSymData = rnd[17:0];
            eyeSync  = (k % 3 == 1);
            iSymEn   = (k % 2 == 1); // half the later eye strobes come without it.
            if (eyeSync) begin
                expI.push_back(iEye[17:2]);
                expQ.push_back(qEye[17:2]);
            end
        end
        @(posedge clk);
        #1;
        eyeSync = 1'b0;
        iSymEn  = 1'b0;
        busWrite(`SDI_CONTROL_ADDR, 32'h0);
        drainAndCheck(6);
    endtask

    task automatic secondCapture();
        sdi_pkg::busWordT d;
        busRead(`SDI_CONTROL_ADDR, d);
        check(d[31], 1'b1, "empty between captures");
        captureSymbols(3);
        busWrite(`SDI_CONTROL_ADDR, 32'h0);
        drainAndCheck(3);
    endtask

    initial begin
        void'($urandom(32'h5f27));
        fifoFull = 1'b1;
        addr     = '0;
        dataIn   = '0;
        wr       = 1'b0;
        iSymEn   = 1'b0;
        iSymData = '0;
        qSymData = '0;
        eyeSync  = 1'b0;
        iEye     = '0;
        qEye     = '0;
        repeat (4) @(posedge clk);
        #1;
        fifoFull = 1'b0;
        resetValues();
        constellationCapture();
        fullStop();
        eyeModeCapture();
        secondCapture();
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+common
common/sdi_pkg.sv
capture/sampleFifo.sv
capture/symbolCapture.sv
uart/frameSerializer.sv
uart/uartTx.sv
rtl/sdiRegs.sv
rtl/sdiTop.sv
tests/sdi_sva.sv
tests/sdiTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= sdiTb
FLIST     ?= src.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= all tests passed

SOURCES := $(shell grep -v '^+' $(FLIST))
HEADERS := $(wildcard common/*.svh)
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
